// ==== flist.f ====
hdl/rta_pkg.sv
hdl/rta_mmio.sv
hdl/rta_ctrl.sv
hdl/tri_mem.sv
hdl/ic_core.sv
hdl/frame_buf.sv
hdl/rta_top.sv
tests/rta_checker.sv
tests/rta_monitor.sv
tests/rta_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rta_tb -f flist.f -o rta_sim

status=0
./obj_dir/rta_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Finished with errors" sim.log \
   || ! grep -q "Finished with no errors" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// ==== tests/rta_tb.sv ====
/* Testbench top with clock, reset, AXI4-Lite tasks, scene table,
   stimulus loop and watchdog */

`timescale 1ns/100ps
`default_nettype none

module rta_tb;

  import rta_pkg::*;

  localparam int NUM_TRI = 16;
  localparam int FB_W    = 8;
  localparam int FB_H    = 8;
  localparam int NPIX    = FB_W * FB_H;
  localparam int NSCENE  = 4;
  localparam int MAXT    = 6;

  logic      clk;
  logic      arst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;

  // Scene table, triangle records and counts
  tri_word_u scene_tri [NSCENE][MAXT];
  int        scene_cnt [NSCENE];
  int        seed;
  bit        table_ready;
  logic [1:0]  resp;
  logic [31:0] rdata;
  // Edge of the last AW and AR handshakes
  time         aw_time;
  time         ar_time;

  rta_top #(.NUM_TRI(NUM_TRI), .FB_W(FB_W), .FB_H(FB_H)) uut (
    .clk      (clk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  rta_monitor #(.NUM_TRI(NUM_TRI), .FB_W(FB_W), .FB_H(FB_H)) mon (
    .clk      (clk),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==========================================================
  // AXI4-Lite master tasks
  // ==========================================================
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input int bdly, output logic [1:0] rsp);
    @(posedge clk);
    #2;
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wvalid  = 1'b1;
    do @(negedge clk); while (!(axil_rsp.awready && axil_rsp.wready));
    @(posedge clk);
    aw_time = $time;
    #2;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    // Hold off bready to stall the response
    repeat (bdly) begin
      @(posedge clk);
      #2;
    end
    axil_req.bready = 1'b1;
    do @(negedge clk); while (!axil_rsp.bvalid);
    rsp = axil_rsp.bresp;
    @(posedge clk);
    #2;
    axil_req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [31:0] addr, input int rdly,
                          output logic [31:0] data, output logic [1:0] rsp);
    @(posedge clk);
    #2;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    do @(negedge clk); while (!axil_rsp.arready);
    @(posedge clk);
    ar_time = $time;
    #2;
    axil_req.arvalid = 1'b0;
    repeat (rdly) begin
      @(posedge clk);
      #2;
    end
    axil_req.rready = 1'b1;
    do @(negedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    rsp  = axil_rsp.rresp;
    @(posedge clk);
    #2;
    axil_req.rready = 1'b0;
  endtask

  // ==========================================================
  // Scene building
  // ==========================================================
  function automatic tri_word_u make_tri(int x0, int y0, int x1, int y1,
                                         int x2, int y2, int z, int sid);
    tri_word_u w;
    w.rec.v0x = coord_t'(x0);
    w.rec.v0y = coord_t'(y0);
    w.rec.v1x = coord_t'(x1);
    w.rec.v1y = coord_t'(y1);
    w.rec.v2x = coord_t'(x2);
    w.rec.v2y = coord_t'(y2);
    w.rec.z   = coord_t'(z);
    w.rec.sid = 16'(sid);
    return w;
  endfunction

  function automatic int rnd(int lo, int hi);
    int r;
    r = $random(seed);
    return lo + int'($unsigned(r) % 32'(hi - lo + 1));
  endfunction

  task automatic build_scenes();
    // Overlap at two depths, opposite windings, a degenerate line
    scene_cnt[0] = 3;
    scene_tri[0][0] = make_tri(0, 0, 7, 0, 0, 7, 10, 16'h0001);
    scene_tri[0][1] = make_tri(1, 1, 7, 7, 7, 1, 5, 16'h0002);
    scene_tri[0][2] = make_tri(0, 0, 3, 3, 7, 7, 1, 16'h0003);
    // Equal depths, lower index wins the tie
    scene_cnt[1] = 2;
    scene_tri[1][0] = make_tri(0, 0, 7, 0, 7, 7, 4, 16'h0010);
    scene_tri[1][1] = make_tri(0, 0, 7, 0, 0, 7, 4, 16'h0011);
    // Empty scene
    scene_cnt[2] = 0;
    // Random triangles partly off screen
    scene_cnt[3] = MAXT;
    for (int t = 0; t < MAXT; t++) begin
      scene_tri[3][t] = make_tri(rnd(-2, 9), rnd(-2, 9), rnd(-2, 9), rnd(-2, 9),
                                 rnd(-2, 9), rnd(-2, 9), rnd(-8, 8), rnd(1, 999));
    end
  endtask

  // ==========================================================
  // Stimulus
  // ==========================================================
  task automatic run_scene(int s);
    int  cnt;
    time start_t;
    cnt = scene_cnt[s];
    axi_write(REG_TRI_COUNT, 32'(cnt), 0, resp);
    mon.check_value("TRI_COUNT bresp", 32'(resp), 32'(RESP_OKAY));
    axi_read(REG_TRI_COUNT, 0, rdata, resp);
    mon.check_value("TRI_COUNT readback", rdata, 32'(cnt));
    axi_write(REG_TRI_SEL, 32'h0, 1, resp);
    for (int t = 0; t < cnt; t++) begin
      for (int k = 0; k < 4; k++) begin
        axi_write(REG_TRI_DATA, scene_tri[s][t].raw[k], (t + k) % 3, resp);
        mon.check_value("TRI_DATA bresp", 32'(resp), 32'(RESP_OKAY));
      end
    end
    // Selector stepped once per data word
    axi_read(REG_TRI_SEL, 0, rdata, resp);
    mon.check_value("TRI_SEL after load", rdata, 32'(4 * cnt));
    axi_write(REG_CTRL, 32'h1, 0, resp);
    start_t = aw_time;
    axi_read(REG_STATUS, 0, rdata, resp);
    mon.check_value("STATUS after start", rdata, 32'h2);
    if (s == 0) begin
      // Second start and a triangle write during the render
      axi_write(REG_CTRL, 32'h1, 2, resp);
      mon.check_value("CTRL while busy bresp", 32'(resp), 32'(RESP_OKAY));
      axi_write(REG_TRI_DATA, 32'hdead_beef, 0, resp);
      mon.check_value("TRI_DATA while busy bresp", 32'(resp), 32'(RESP_SLVERR));
      axi_read(REG_TRI_SEL, 1, rdata, resp);
      mon.check_value("TRI_SEL while busy", rdata, 32'(4 * cnt));
    end
    do axi_read(REG_STATUS, 0, rdata, resp); while (!rdata[0]);
    mon.check_value("STATUS at end", rdata, 32'h1);
    if (cnt > 0) begin
      // Done seen within one poll period of the nominal render length
      mon.check_range("render cycles", int'((ar_time - start_t) / 20),
                      NPIX * cnt + 5, NPIX * cnt + 9);
    end
    // Monitor compares every pixel
    for (int p = 0; p < NPIX; p++) begin
      axi_read(FB_BASE + 32'(4 * p), p % 3, rdata, resp);
      mon.check_value("frame buffer rresp", 32'(resp), 32'(RESP_OKAY));
    end
  endtask

  // Watchdog budget from the scene lengths
  initial begin
    longint cycles;
    wait (table_ready);
    cycles = 400;
    for (int s = 0; s < NSCENE; s++) begin
      cycles += NPIX * scene_cnt[s] + 5 + scene_cnt[s] * 4 * 10 + NPIX * 10 + 200;
    end
    #(20 * cycles * 20);
    $display("Watchdog timeout, the run did not complete in time");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    axil_req    = '0;
    arst_n      = 1'b0;
    seed        = 91;
    table_ready = 1'b0;
    build_scenes();
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;

    for (int s = 0; s < NSCENE; s++) begin
      run_scene(s);
    end

    // Unmapped addresses
    axi_write(32'h0000_000c, 32'h5, 1, resp);
    mon.check_value("unmapped write bresp", 32'(resp), 32'(RESP_SLVERR));
    axi_read(32'h0000_0020, 0, rdata, resp);
    mon.check_value("unmapped read rresp", 32'(resp), 32'(RESP_SLVERR));
    mon.check_value("unmapped read data", rdata, 32'h0);
    axi_read(FB_BASE + 32'(4 * NPIX), 2, rdata, resp);
    mon.check_value("past frame buffer rresp", 32'(resp), 32'(RESP_SLVERR));
    // Image of the last scene still intact
    for (int p = 0; p < NPIX; p += 7) begin
      axi_read(FB_BASE + 32'(4 * p), 1, rdata, resp);
    end

    repeat (4) @(posedge clk);
    $display("Errors: %0d", mon.errors);
    if (mon.errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/rta_monitor.sv ====
/* AXI4-Lite watcher with a shadow triangle store, per-pixel
   expected values and error counting */

`timescale 1ns/100ps
`default_nettype none

module rta_monitor #(
  parameter int NUM_TRI = 16,
  parameter int FB_W    = 8,
  parameter int FB_H    = 8
) (
  input wire                      clk,
  input wire rta_pkg::axil_req_t  axil_req,
  input wire rta_pkg::axil_rsp_t  axil_rsp
);

  import rta_pkg::*;

  localparam int NPIX = FB_W * FB_H;

  int          errors = 0;
  logic [31:0] words [NUM_TRI][4];
  logic [7:0]  sel = 8'h0;
  int          count = 0;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic [31:0] rd_addr;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_range(input string what, input int got, input int lo,
                             input int hi);
    if (got < lo || got > hi) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d to %0d",
               $time, what, got, lo, hi);
    end
  endtask

  // Nearest hit over the loaded triangles, {hit, sid}
  function automatic logic [31:0] expect_pixel(int x, int y);
    int          vx [3];
    int          vy [3];
    int          e [3];
    int          n;
    int          area;
    int          z;
    int          best_z;
    logic        any;
    logic [15:0] best_sid;
    any      = 1'b0;
    best_z   = 0;
    best_sid = 16'h0;
    for (int t = 0; t < count; t++) begin
      for (int k = 0; k < 3; k++) begin
        vx[k] = int'($signed(words[t][k][15:0]));
        vy[k] = int'($signed(words[t][k][31:16]));
      end
      for (int k = 0; k < 3; k++) begin
        n    = (k + 1) % 3;
        e[k] = (vx[n] - vx[k]) * (y - vy[k]) - (vy[n] - vy[k]) * (x - vx[k]);
      end
      area = (vx[1] - vx[0]) * (vy[2] - vy[0]) - (vy[1] - vy[0]) * (vx[2] - vx[0]);
      z    = int'($signed(words[t][3][15:0]));
      if (area != 0 && ((e[0] >= 0 && e[1] >= 0 && e[2] >= 0) ||
                        (e[0] <= 0 && e[1] <= 0 && e[2] <= 0))) begin
        // Strictly nearer replaces, so ties keep the earlier one
        if (!any || z < best_z) begin
          any      = 1'b1;
          best_z   = z;
          best_sid = words[t][3][31:16];
        end
      end
    end
    return {15'b0, any, best_sid};
  endfunction

  // Sampled mid-cycle, the handshake lands on the next rising edge
  always @(negedge clk) begin
    int pix;
    if (axil_req.awvalid && axil_req.wvalid && axil_rsp.awready && axil_rsp.wready) begin
      wr_addr = axil_req.awaddr;
      wr_data = axil_req.wdata;
    end
    // Register effects only once the write was accepted with OKAY
    if (axil_rsp.bvalid && axil_req.bready && axil_rsp.bresp == RESP_OKAY) begin
      if (wr_addr == REG_TRI_SEL) begin
        sel = wr_data[7:0];
      end else if (wr_addr == REG_TRI_COUNT) begin
        count = (wr_data > 32'(NUM_TRI)) ? NUM_TRI : int'(wr_data[7:0]);
      end else if (wr_addr == REG_TRI_DATA) begin
        if (int'(sel[7:2]) < NUM_TRI) begin
          words[sel[7:2]][sel[1:0]] = wr_data;
        end
        sel = sel + 8'd1;
      end
    end
    if (axil_req.arvalid && axil_rsp.arready) begin
      rd_addr = axil_req.araddr;
    end
    if (axil_rsp.rvalid && axil_req.rready && rd_addr >= FB_BASE &&
        rd_addr < FB_BASE + 32'(4 * NPIX)) begin
      pix = int'((rd_addr - FB_BASE) >> 2);
      check_value($sformatf("pixel (%0d,%0d)", pix % FB_W, pix / FB_W),
                  axil_rsp.rdata, expect_pixel(pix % FB_W, pix / FB_W));
    end
  end

endmodule

`default_nettype wire

// ==== tests/rta_checker.sv ====
/* AXI4-Lite response hold, response stability and status assertions */

`timescale 1ns/100ps
`default_nettype none

module rta_checker (
  input wire                      clk,
  input wire                      arst_n,
  input wire rta_pkg::axil_req_t  axil_req,
  input wire rta_pkg::axil_rsp_t  axil_rsp,
  input wire                      busy,
  input wire                      done
);

  // Response valids wait for ready
  b_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");
  r_hold: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid)
    else $error("rvalid dropped before rready");

  // Stalled responses keep their payload
  b_stable: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.bvalid && !axil_req.bready |=> $stable(axil_rsp.bresp))
    else $error("write response changed while stalled");
  r_stable: assert property (@(posedge clk) disable iff (!arst_n)
    axil_rsp.rvalid && !axil_req.rready |=>
      $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else $error("read response changed while stalled");

  no_busy_done: assert property (@(posedge clk) disable iff (!arst_n) !(busy && done))
    else $error("busy and done high together");

endmodule

bind rta_top rta_checker chk (
  .clk      (clk),
  .arst_n   (arst_n),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .busy     (busy),
  .done     (done)
);

`default_nettype wire

// ==== hdl/rta_top.sv ====
/* Accelerator top, AXI4-Lite port and block wiring */

`timescale 1ns/100ps
`default_nettype none

module rta_top #(
  parameter int NUM_TRI = 16,
  parameter int FB_W    = 8,
  parameter int FB_H    = 8
) (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire  rta_pkg::axil_req_t  axil_req,
  output rta_pkg::axil_rsp_t        axil_rsp
);

  import rta_pkg::*;

  localparam int TI_W = $clog2(NUM_TRI);
  localparam int PA_W = $clog2(FB_W * FB_H);

  // Command path
  logic            start;
  logic            busy;
  logic            done;
  logic [7:0]      tri_count;
  // Triangle load
  logic            tri_we;
  logic [TI_W-1:0] tri_wr_idx;
  logic [1:0]      tri_wr_word;
  logic [31:0]     tri_wr_data;
  // Triangle fetch
  logic [TI_W-1:0] tri_rd_idx;
  tri_word_u       tri_rd;
  ray_pair_t       pair;
  logic            pair_valid;
  // Results
  pix_result_t     result;
  logic            result_valid;
  logic [PA_W-1:0] fb_rd_addr;
  logic [16:0]     fb_rd_data;

  rta_mmio #(.NUM_TRI(NUM_TRI), .FB_W(FB_W), .FB_H(FB_H)) u_mmio (
    .clk         (clk),
    .arst_n      (arst_n),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .tri_count   (tri_count),
    .tri_we      (tri_we),
    .tri_wr_idx  (tri_wr_idx),
    .tri_wr_word (tri_wr_word),
    .tri_wr_data (tri_wr_data),
    .fb_rd_addr  (fb_rd_addr),
    .fb_rd_data  (fb_rd_data)
  );

  rta_ctrl #(.NUM_TRI(NUM_TRI), .FB_W(FB_W), .FB_H(FB_H)) u_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .tri_count  (tri_count),
    .busy       (busy),
    .done       (done),
    .tri_rd_idx (tri_rd_idx),
    .pair       (pair),
    .pair_valid (pair_valid)
  );

  tri_mem #(.NUM_TRI(NUM_TRI)) u_tri_mem (
    .clk     (clk),
    .we      (tri_we),
    .wr_idx  (tri_wr_idx),
    .wr_word (tri_wr_word),
    .wr_data (tri_wr_data),
    .rd_idx  (tri_rd_idx),
    .rd_data (tri_rd)
  );

  ic_core #(.FB_W(FB_W)) u_ic_core (
    .clk          (clk),
    .arst_n       (arst_n),
    .pair         (pair),
    .pair_valid   (pair_valid),
    .tri_word     (tri_rd),
    .result       (result),
    .result_valid (result_valid)
  );

  frame_buf #(.FB_W(FB_W), .FB_H(FB_H)) u_frame_buf (
    .clk     (clk),
    .we      (result_valid),
    .wr      (result),
    .rd_addr (fb_rd_addr),
    .rd_data (fb_rd_data)
  );

endmodule

`default_nettype wire

// ==== hdl/frame_buf.sv ====
/* Per-pixel result memory with registered read */

`timescale 1ns/100ps
`default_nettype none

module frame_buf #(
  parameter int FB_W = 8,
  parameter int FB_H = 8
) (
  input  wire                            clk,
  input  wire                            we,
  input  wire  rta_pkg::pix_result_t     wr,
  input  wire  [$clog2(FB_W*FB_H)-1:0]   rd_addr,
  output logic [16:0]                    rd_data
);

  localparam int NPIX = FB_W * FB_H;
  localparam int PA_W = $clog2(NPIX);

  // Entry is {hit, sid}
  logic [16:0] mem [NPIX];

  always_ff @(posedge clk) begin
    // A miss stores zero sid
    if (we) begin
      mem[wr.pix[PA_W-1:0]] <= {wr.hit, wr.hit ? wr.sid : 16'h0000};
    end
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/ic_core.sv ====
/* Three-stage edge-function intersection pipeline with nearest-hit
   tracking per pixel */

`timescale 1ns/100ps
`default_nettype none

module ic_core #(
  parameter int FB_W = 8
) (
  input  wire                       clk,
  input  wire                       arst_n,
  input  wire  rta_pkg::ray_pair_t  pair,
  input  wire                       pair_valid,
  input  wire  rta_pkg::tri_word_u  tri_word,
  output rta_pkg::pix_result_t      result,
  output logic                      result_valid
);

  import rta_pkg::*;

  // ==========================================================
  // Stage 1 forms edge and ray differences
  // ==========================================================
  coord_t             vx [3];
  coord_t             vy [3];
  logic signed [16:0] rx;
  logic signed [16:0] ry;

  logic               s1_valid;
  ray_pair_t          s1_pair;
  coord_t             s1_z;
  logic [15:0]        s1_sid;
  logic signed [16:0] s1_dx [3];
  logic signed [16:0] s1_dy [3];
  logic signed [16:0] s1_qx [3];
  logic signed [16:0] s1_qy [3];

  assign vx[0] = tri_word.rec.v0x;
  assign vy[0] = tri_word.rec.v0y;
  assign vx[1] = tri_word.rec.v1x;
  assign vy[1] = tri_word.rec.v1y;
  assign vx[2] = tri_word.rec.v2x;
  assign vy[2] = tri_word.rec.v2y;
  // Ray origin at the pixel
  assign rx = {9'b0, pair.px};
  assign ry = {9'b0, pair.py};

  always_ff @(posedge clk) begin
    // Edge i runs from vertex i to vertex i+1
    for (int i = 0; i < 3; i++) begin
      s1_dx[i] <= vx[(i + 1) % 3] - vx[i];
      s1_dy[i] <= vy[(i + 1) % 3] - vy[i];
      s1_qx[i] <= rx - vx[i];
      s1_qy[i] <= ry - vy[i];
    end
    s1_pair <= pair;
    s1_z    <= tri_word.rec.z;
    s1_sid  <= tri_word.rec.sid;
  end

  // ==========================================================
  // Stage 2 multiplies into edge values and area
  // ==========================================================
  logic               s2_valid;
  ray_pair_t          s2_pair;
  coord_t             s2_z;
  logic [15:0]        s2_sid;
  logic signed [31:0] s2_e [3];
  logic signed [31:0] s2_area;

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      s2_e[i] <= 32'(s1_dx[i]) * 32'(s1_qy[i]) - 32'(s1_dy[i]) * 32'(s1_qx[i]);
    end
    // Cross product of edge 0 with the reversed edge 2
    s2_area <= 32'(s1_dy[0]) * 32'(s1_dx[2]) - 32'(s1_dx[0]) * 32'(s1_dy[2]);
    s2_pair <= s1_pair;
    s2_z    <= s1_z;
    s2_sid  <= s1_sid;
  end

  // ==========================================================
  // Stage 3 resolves the nearest hit
  // ==========================================================
  logic        hit;
  logic        base_hit;
  logic        take;
  logic        best_hit;
  coord_t      best_z;
  logic [15:0] best_sid;

  // Either winding counts, degenerate and empty never hit
  assign hit = (s2_pair.tri_idx != TRI_NONE) && (s2_area != 32'sd0) &&
               (((s2_e[0] >= 0) && (s2_e[1] >= 0) && (s2_e[2] >= 0)) ||
                ((s2_e[0] <= 0) && (s2_e[1] <= 0) && (s2_e[2] <= 0)));

  // First pair of a pixel starts from a miss
  assign base_hit = s2_pair.first ? 1'b0 : best_hit;
  // Strictly nearer only, so ties keep the lower index
  assign take = hit && (!base_hit || (s2_z < best_z));

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      if (take) begin
        best_hit <= 1'b1;
        best_z   <= s2_z;
        best_sid <= s2_sid;
      end else begin
        best_hit <= base_hit;
      end
      result.pix <= 16'(s2_pair.py) * 16'(FB_W) + 16'(s2_pair.px);
      result.hit <= take | base_hit;
      result.sid <= take ? s2_sid : best_sid;
    end
  end

  // Valid pipe, result only on the last pair
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid     <= 1'b0;
      s2_valid     <= 1'b0;
      result_valid <= 1'b0;
    end else begin
      s1_valid     <= pair_valid;
      s2_valid     <= s1_valid;
      result_valid <= s2_valid && s2_pair.last;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tri_mem.sv ====
/* Triangle storage, word writes and whole-triangle registered read */

`timescale 1ns/100ps
`default_nettype none

module tri_mem #(
  parameter int NUM_TRI = 16
) (
  input  wire                          clk,
  input  wire                          we,
  input  wire  [$clog2(NUM_TRI)-1:0]   wr_idx,
  input  wire  [1:0]                   wr_word,
  input  wire  [31:0]                  wr_data,
  input  wire  [$clog2(NUM_TRI)-1:0]   rd_idx,
  output rta_pkg::tri_word_u           rd_data
);

  import rta_pkg::*;

  tri_word_u mem [NUM_TRI];

  always_ff @(posedge clk) begin
    // Register side writes one raw word
    if (we) begin
      mem[wr_idx].raw[wr_word] <= wr_data;
    end
    // Whole triangle out for the core
    rd_data <= mem[rd_idx];
  end

endmodule

`default_nettype wire

// ==== hdl/rta_ctrl.sv ====
/* Command processor FSM walking pixels and triangles */

`timescale 1ns/100ps
`default_nettype none

module rta_ctrl #(
  parameter int NUM_TRI = 16,
  parameter int FB_W    = 8,
  parameter int FB_H    = 8
) (
  input  wire                          clk,
  input  wire                          arst_n,
  input  wire                          start,
  input  wire  [7:0]                   tri_count,
  output logic                         busy,
  output logic                         done,
  output logic [$clog2(NUM_TRI)-1:0]   tri_rd_idx,
  output rta_pkg::ray_pair_t           pair,
  output logic                         pair_valid
);

  import rta_pkg::*;

  // Cycles after the last issue until its result is stored
  localparam logic [2:0] DRAIN_CYC = 3'd3;

  typedef enum logic [1:0] {
    S_IDLE,
    S_RUN,
    S_DRAIN
  } state_t;

  state_t     state;
  logic [7:0] px;
  logic [7:0] py;
  logic [7:0] ti;
  // Triangle count latched at start
  logic [7:0] tc;
  logic [2:0] drain_cnt;
  logic       tri_last;
  logic       pix_last;
  ray_pair_t  cur;

  assign busy       = (state != S_IDLE);
  assign tri_rd_idx = ti[$clog2(NUM_TRI)-1:0];

  // Empty scene gives a single pair per pixel
  assign tri_last = (tc == 8'd0) || (ti == tc - 8'd1);
  assign pix_last = (px == 8'(FB_W - 1)) && (py == 8'(FB_H - 1));

  always_comb begin
    cur.px      = px;
    cur.py      = py;
    cur.tri_idx = (tc == 8'd0) ? TRI_NONE : ti;
    cur.first   = (ti == 8'd0);
    cur.last    = tri_last;
  end

  // ==========================================================
  // Sequencer
  // ==========================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= S_IDLE;
      done       <= 1'b0;
      px         <= '0;
      py         <= '0;
      ti         <= '0;
      tc         <= '0;
      drain_cnt  <= '0;
      pair_valid <= 1'b0;
    end else begin
      // Issue in RUN shows up one cycle later
      pair_valid <= (state == S_RUN);
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_RUN;
            done  <= 1'b0;
            tc    <= tri_count;
            px    <= '0;
            py    <= '0;
            ti    <= '0;
          end
        end
        S_RUN: begin
          if (!tri_last) begin
            ti <= ti + 8'd1;
          end else begin
            // Next pixel in raster order
            ti <= '0;
            if (px == 8'(FB_W - 1)) begin
              px <= '0;
              py <= py + 8'd1;
            end else begin
              px <= px + 8'd1;
            end
            if (pix_last) begin
              state     <= S_DRAIN;
              drain_cnt <= DRAIN_CYC;
            end
          end
        end
        S_DRAIN: begin
          // Wait for the pipeline and the frame buffer write
          if (drain_cnt == 3'd0) begin
            state <= S_IDLE;
            done  <= 1'b1;
          end else begin
            drain_cnt <= drain_cnt - 3'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Lines the pair up with the triangle read data
  always_ff @(posedge clk) begin
    pair <= cur;
  end

endmodule

`default_nettype wire

// ==== hdl/rta_mmio.sv ====
/* AXI4-Lite register slave with triangle word writes, start pulse
   and frame-buffer read forwarding */

`timescale 1ns/100ps
`default_nettype none

module rta_mmio #(
  parameter int NUM_TRI = 16,
  parameter int FB_W    = 8,
  parameter int FB_H    = 8
) (
  input  wire                              clk,
  input  wire                              arst_n,
  input  wire  rta_pkg::axil_req_t         axil_req,
  output rta_pkg::axil_rsp_t               axil_rsp,
  output logic                             start,
  input  wire                              busy,
  input  wire                              done,
  output logic [7:0]                       tri_count,
  output logic                             tri_we,
  output logic [$clog2(NUM_TRI)-1:0]       tri_wr_idx,
  output logic [1:0]                       tri_wr_word,
  output logic [31:0]                      tri_wr_data,
  output logic [$clog2(FB_W*FB_H)-1:0]     fb_rd_addr,
  input  wire  [16:0]                      fb_rd_data
);

  import rta_pkg::*;

  localparam int NPIX = FB_W * FB_H;
  localparam int TI_W = $clog2(NUM_TRI);
  localparam int PA_W = $clog2(NPIX);

  // Triangle index in 7:2, word in 1:0
  logic [7:0]  tri_sel;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        rvalid;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  // Frame buffer read waiting on the memory
  logic        fb_pend;
  logic        run_any;
  logic        wr_go;
  logic        rd_go;
  logic        wr_err;
  logic        rd_err;
  logic [31:0] rd_word;
  logic [31:0] fb_off;
  logic        fb_sel;
  logic        sel_ok;

  // Render counts as running while the start pulse is in flight
  assign run_any = busy | start;

  // AW and W go together, one outstanding response per channel
  assign wr_go = axil_req.awvalid & axil_req.wvalid & ~bvalid;
  assign rd_go = axil_req.arvalid & ~rvalid & ~fb_pend;

  // Frame buffer window
  assign fb_off     = axil_req.araddr - FB_BASE;
  assign fb_sel     = (axil_req.araddr >= FB_BASE) && (fb_off < 32'(4 * NPIX));
  // Memory registers this address on the AR edge
  assign fb_rd_addr = fb_off[PA_W+1:2];

  // Triangle port is written straight from the W beat
  assign sel_ok      = {2'b00, tri_sel[7:2]} < 8'(NUM_TRI);
  assign tri_we      = wr_go && (axil_req.awaddr == REG_TRI_DATA) && !run_any && sel_ok;
  assign tri_wr_idx  = tri_sel[TI_W+1:2];
  assign tri_wr_word = tri_sel[1:0];
  assign tri_wr_data = axil_req.wdata;

  // Write decode
  always_comb begin
    case (axil_req.awaddr)
      REG_CTRL, REG_STATUS, REG_TRI_COUNT, REG_TRI_SEL: wr_err = 1'b0;
      // No triangle updates during a render
      REG_TRI_DATA: wr_err = run_any;
      default:      wr_err = 1'b1;
    endcase
  end

  // Read decode, data stays 0 on error
  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    case (axil_req.araddr)
      REG_CTRL, REG_TRI_DATA: rd_word = '0;
      // Done drops together with the start pulse
      REG_STATUS:    rd_word = {30'b0, run_any, done & ~start};
      REG_TRI_COUNT: rd_word = {24'b0, tri_count};
      REG_TRI_SEL:   rd_word = {24'b0, tri_sel};
      default:       rd_err  = !fb_sel;
    endcase
  end

  // ==========================================================
  // Write channel and registers
  // ==========================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bvalid    <= 1'b0;
      bresp     <= RESP_OKAY;
      start     <= 1'b0;
      tri_count <= '0;
      tri_sel   <= '0;
    end else begin
      start <= 1'b0;
      if (bvalid && axil_req.bready) begin
        bvalid <= 1'b0;
      end
      if (wr_go) begin
        bvalid <= 1'b1;
        bresp  <= wr_err ? RESP_SLVERR : RESP_OKAY;
        case (axil_req.awaddr)
          REG_CTRL:      start <= axil_req.wdata[0] & ~run_any;
          // Clamp to the memory size
          REG_TRI_COUNT: tri_count <= (axil_req.wdata > 32'(NUM_TRI)) ?
                                      8'(NUM_TRI) : axil_req.wdata[7:0];
          REG_TRI_SEL:   tri_sel <= axil_req.wdata[7:0];
          REG_TRI_DATA: begin
            // Step to the next word
            if (!run_any) begin
              tri_sel <= tri_sel + 8'd1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // ==========================================================
  // Read channel
  // ==========================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rvalid  <= 1'b0;
      fb_pend <= 1'b0;
    end else begin
      if (rvalid && axil_req.rready) begin
        rvalid <= 1'b0;
      end
      if (rd_go) begin
        fb_pend <= fb_sel;
        rvalid  <= !fb_sel;
      end
      // Memory data is ready one cycle later
      if (fb_pend) begin
        fb_pend <= 1'b0;
        rvalid  <= 1'b1;
      end
    end
  end

  // Read payload, held while rvalid waits
  always_ff @(posedge clk) begin
    if (rd_go) begin
      rdata <= rd_word;
      rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end else if (fb_pend) begin
      rdata <= {15'b0, fb_rd_data};
    end
  end

  always_comb begin
    axil_rsp.awready = ~bvalid;
    axil_rsp.wready  = ~bvalid;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = bresp;
    axil_rsp.arready = ~(rvalid | fb_pend);
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
  end

endmodule

`default_nettype wire

// ==== hdl/rta_pkg.sv ====
/* Triangle union, pair and result structs, AXI4-Lite channel structs,
   register offsets and response codes */

`default_nettype none

package rta_pkg;

  // ==========================================================
  // Geometry
  // ==========================================================

  // Vertex coordinate or depth, two's complement
  typedef logic signed [15:0] coord_t;

  // Triangle record with v0x in the lowest bits
  typedef struct packed {
    logic [15:0] sid;
    coord_t      z;
    coord_t      v2y;
    coord_t      v2x;
    coord_t      v1y;
    coord_t      v1x;
    coord_t      v0y;
    coord_t      v0x;
  } tri_rec_t;

  // Register side sees four raw words
  // raw[0] is {v0y,v0x} and raw[3] is {sid,z}
  typedef union packed {
    tri_rec_t         rec;
    logic [3:0][31:0] raw;
  } tri_word_u;

  // Triangle index for a pixel with nothing to test
  localparam logic [7:0] TRI_NONE = 8'hff;

  // One ray and triangle pair in flight
  typedef struct packed {
    logic [7:0] px;
    logic [7:0] py;
    logic [7:0] tri_idx;
    logic       first;
    logic       last;
  } ray_pair_t;

  // Final value of one pixel
  typedef struct packed {
    logic [15:0] pix;
    logic        hit;
    logic [15:0] sid;
  } pix_result_t;

  // ==========================================================
  // AXI4-Lite
  // ==========================================================

  // Master-driven signals of all five channels
  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  // Slave-driven signals
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Register byte offsets
  localparam logic [31:0] REG_CTRL      = 32'h000;
  localparam logic [31:0] REG_STATUS    = 32'h004;
  localparam logic [31:0] REG_TRI_COUNT = 32'h008;
  localparam logic [31:0] REG_TRI_SEL   = 32'h010;
  localparam logic [31:0] REG_TRI_DATA  = 32'h014;
  // Frame buffer window, one word per pixel
  localparam logic [31:0] FB_BASE       = 32'h100;

endpackage

`default_nettype wire
